// ==== hdl/gpu_config.svh ====
`ifndef GPU_CONFIG_SVH
`define GPU_CONFIG_SVH

// datapath widths
`define GPU_COORD_W 16
`define GPU_ADDR_W 32
`define GPU_COLOUR_W 16

// visible framebuffer area, pixels beyond are clipped
`define GPU_FB_WIDTH 400
`define GPU_FB_HEIGHT 240

// sprite sheet pixels are 16 bit, two per 32-bit word
`define GPU_BYTES_PER_PIXEL 2

`endif

// ==== hdl/gpu_pkg.sv ====
`include "gpu_config.svh"

package gpu_pkg;

    typedef logic [`GPU_COORD_W-1:0] coord_t;
    typedef logic [`GPU_ADDR_W-1:0] addr_t;
    typedef logic [`GPU_COLOUR_W-1:0] colour_t;

    typedef enum logic {
        SRC_SOLID,
        SRC_MEMORY
    } draw_src_e;

    typedef enum logic {
        WALK_IDLE,
        WALK_RUN
    } walk_state_e;

    typedef enum logic [1:0] {
        SKID_EMPTY,
        SKID_FULL,
        SKID_BUF_FULL // output and buffer both hold an item
    } skid_state_e;

    typedef enum logic [2:0] {
        FETCH_IDLE,
        FETCH_ADDR,
        FETCH_DATA,
        FETCH_OUT,
        FETCH_HIT
    } fetch_state_e;

endpackage

// ==== hdl/gpu_ifs.sv ====
`timescale 1ns/10ps

// walker to address stage, sheet coordinates plus target pixel
interface walk_if;
    import gpu_pkg::*;

    logic valid;
    logic ready;
    coord_t sheet_x;
    coord_t sheet_y;
    coord_t fb_x;
    coord_t fb_y;

    modport source (output valid, sheet_x, sheet_y, fb_x, fb_y, input ready);
    modport sink (input valid, sheet_x, sheet_y, fb_x, fb_y, output ready);
endinterface

// byte address of one sprite pixel
interface fetch_req_if;
    import gpu_pkg::*;

    logic valid;
    logic ready;
    addr_t addr;
    coord_t fb_x;
    coord_t fb_y;

    modport source (output valid, addr, fb_x, fb_y, input ready);
    modport sink (input valid, addr, fb_x, fb_y, output ready);
endinterface

// finished pixel headed for the framebuffer
interface pixel_if;
    import gpu_pkg::*;

    logic valid;
    logic ready;
    coord_t x;
    coord_t y;
    colour_t colour;

    modport source (output valid, x, y, colour, input ready);
    modport sink (input valid, x, y, colour, output ready);
endinterface

// ==== hdl/rect_walker.sv ====
`timescale 1ns/10ps
`include "gpu_config.svh"

module rect_walker (
    input  logic clk,
    input  logic rst,
    input  logic cmd_valid,
    output logic cmd_ready,
    input  gpu_pkg::coord_t sheet_x,
    input  gpu_pkg::coord_t sheet_y,
    input  gpu_pkg::coord_t screen_x,
    input  gpu_pkg::coord_t screen_y,
    input  gpu_pkg::coord_t width,
    input  gpu_pkg::coord_t height,
    input  logic mirror_x,
    input  logic mirror_y,
    input  gpu_pkg::draw_src_e source,
    input  gpu_pkg::colour_t draw_colour,
    walk_if.source coord,
    pixel_if.source solid
);
    import gpu_pkg::*;

    walk_state_e state;
    logic out_valid;
    logic out_ready;

    coord_t start_x;
    coord_t start_y;
    coord_t ss_x0;
    coord_t ss_y0;
    coord_t width_q;
    coord_t height_q;
    logic mir_x_q;
    logic mir_y_q;
    draw_src_e src_q;
    colour_t colour_q;

    coord_t ox; // offsets inside the rectangle
    coord_t oy;
    coord_t x_first;
    coord_t x_last;
    coord_t y_last;

    coord_t room_x;
    coord_t room_y;
    coord_t vis_w;
    coord_t vis_h;
    coord_t scr_x;
    coord_t scr_y;

    wire cmd_xfer = cmd_valid && cmd_ready;
    wire out_xfer = out_valid && out_ready;

    // visible span after right and bottom clipping
    always_comb begin
        room_x = coord_t'(`GPU_FB_WIDTH) - screen_x;
        room_y = coord_t'(`GPU_FB_HEIGHT) - screen_y;
        if (screen_x >= coord_t'(`GPU_FB_WIDTH))
            vis_w = '0;
        else if (width < room_x)
            vis_w = width;
        else
            vis_w = room_x;
        if (screen_y >= coord_t'(`GPU_FB_HEIGHT))
            vis_h = '0;
        else if (height < room_y)
            vis_h = height;
        else
            vis_h = room_y;
    end

    assign cmd_ready = (state == WALK_IDLE);
    assign out_ready = (src_q == SRC_SOLID) ? solid.ready : coord.ready;

    assign scr_x = mir_x_q ? start_x + (width_q - coord_t'(1)) - ox : start_x + ox;
    assign scr_y = mir_y_q ? start_y + (height_q - coord_t'(1)) - oy : start_y + oy;

    assign coord.valid = out_valid && (src_q == SRC_MEMORY);
    assign coord.sheet_x = ss_x0 + ox; // sheet side never mirrored
    assign coord.sheet_y = ss_y0 + oy;
    assign coord.fb_x = scr_x;
    assign coord.fb_y = scr_y;

    assign solid.valid = out_valid && (src_q == SRC_SOLID);
    assign solid.x = scr_x;
    assign solid.y = scr_y;
    assign solid.colour = colour_q;

    always_ff @(posedge clk) begin
        case (state)
            WALK_IDLE: begin
                if (cmd_xfer) begin
                    state <= WALK_RUN;
                    out_valid <= (vis_w != '0) && (vis_h != '0);
                    start_x <= screen_x;
                    start_y <= screen_y;
                    ss_x0 <= sheet_x;
                    ss_y0 <= sheet_y;
                    width_q <= width;
                    height_q <= height;
                    mir_x_q <= mirror_x;
                    mir_y_q <= mirror_y;
                    src_q <= source;
                    colour_q <= draw_colour;
                    // mirrored spans sit at the top end of the offsets
                    ox <= mirror_x ? width - vis_w : '0;
                    oy <= mirror_y ? height - vis_h : '0;
                    x_first <= mirror_x ? width - vis_w : '0;
                    x_last <= mirror_x ? width - coord_t'(1) : vis_w - coord_t'(1);
                    y_last <= mirror_y ? height - coord_t'(1) : vis_h - coord_t'(1);
                end
            end
            WALK_RUN: begin
                if (!out_valid) begin
                    state <= WALK_IDLE; // nothing visible
                end else if (out_xfer) begin
                    if (ox == x_last) begin
                        ox <= x_first;
                        if (oy == y_last) begin
                            out_valid <= 1'b0;
                            state <= WALK_IDLE;
                        end else begin
                            oy <= oy + coord_t'(1);
                        end
                    end else begin
                        ox <= ox + coord_t'(1);
                    end
                end
            end
        endcase

        if (rst) begin
            state <= WALK_IDLE;
            out_valid <= 1'b0;
        end
    end

endmodule

// ==== hdl/pixel_address.sv ====
`timescale 1ns/10ps
`include "gpu_config.svh"

module pixel_address (
    input  logic clk,
    input  logic rst,
    input  gpu_pkg::addr_t image_start,
    input  gpu_pkg::coord_t image_width,
    walk_if.sink coord,
    fetch_req_if.source req,
    output logic idle
);
    import gpu_pkg::*;

    skid_state_e state;
    addr_t linear;
    addr_t byte_addr;

    addr_t out_addr;
    coord_t out_x;
    coord_t out_y;
    addr_t buf_addr; // second entry, only used under back-pressure
    coord_t buf_x;
    coord_t buf_y;

    wire in_xfer = coord.valid && coord.ready;
    wire out_xfer = req.valid && req.ready;

    assign linear = addr_t'(coord.sheet_x) + addr_t'(image_width) * addr_t'(coord.sheet_y);
    assign byte_addr = image_start + addr_t'(`GPU_BYTES_PER_PIXEL) * linear;

    assign coord.ready = (state != SKID_BUF_FULL);
    assign req.valid = (state != SKID_EMPTY);
    assign req.addr = out_addr;
    assign req.fb_x = out_x;
    assign req.fb_y = out_y;
    assign idle = (state == SKID_EMPTY);

    always_ff @(posedge clk) begin
        case (state)
            SKID_EMPTY: begin
                if (in_xfer) begin
                    out_addr <= byte_addr;
                    out_x <= coord.fb_x;
                    out_y <= coord.fb_y;
                    state <= SKID_FULL;
                end
            end
            SKID_FULL: begin
                if (in_xfer && !out_xfer) begin
                    buf_addr <= byte_addr;
                    buf_x <= coord.fb_x;
                    buf_y <= coord.fb_y;
                    state <= SKID_BUF_FULL;
                end else if (in_xfer && out_xfer) begin
                    out_addr <= byte_addr;
                    out_x <= coord.fb_x;
                    out_y <= coord.fb_y;
                end else if (out_xfer) begin
                    state <= SKID_EMPTY;
                end
            end
            SKID_BUF_FULL: begin
                if (out_xfer) begin
                    out_addr <= buf_addr;
                    out_x <= buf_x;
                    out_y <= buf_y;
                    state <= SKID_FULL;
                end
            end
            default: state <= SKID_EMPTY;
        endcase

        if (rst)
            state <= SKID_EMPTY;
    end

endmodule

// ==== hdl/pixel_fetch.sv ====
`timescale 1ns/10ps
`include "gpu_config.svh"

module pixel_fetch (
    input  logic clk,
    input  logic rst,
    fetch_req_if.sink req,
    pixel_if.source pix,
    output gpu_pkg::addr_t m_axil_araddr,
    output logic m_axil_arvalid,
    input  logic m_axil_arready,
    input  logic [31:0] m_axil_rdata,
    input  logic m_axil_rvalid,
    output logic m_axil_rready,
    output logic idle
);
    import gpu_pkg::*;

    fetch_state_e state;

    // one-word cache of the last read
    logic cache_valid;
    logic [`GPU_ADDR_W-3:0] cache_tag;
    logic [31:0] cache_word;

    logic half_sel; // address bit 1 picks the upper pixel
    coord_t x_q;
    coord_t y_q;

    wire req_xfer = req.valid && req.ready;
    wire pix_xfer = pix.valid && pix.ready;
    wire ar_xfer = m_axil_arvalid && m_axil_arready;
    wire r_xfer = m_axil_rvalid && m_axil_rready;
    wire hit = cache_valid && (cache_tag == req.addr[`GPU_ADDR_W-1:2]);

    assign req.ready = (state == FETCH_IDLE);
    assign idle = (state == FETCH_IDLE);

    assign pix.valid = (state == FETCH_OUT) || (state == FETCH_HIT);
    assign pix.colour = half_sel ? cache_word[31:16] : cache_word[15:0];
    assign pix.x = x_q;
    assign pix.y = y_q;

    always_ff @(posedge clk) begin
        case (state)
            FETCH_IDLE: begin
                if (req_xfer) begin
                    half_sel <= req.addr[1];
                    x_q <= req.fb_x;
                    y_q <= req.fb_y;
                    if (hit) begin
                        state <= FETCH_HIT;
                    end else begin
                        m_axil_araddr <= {req.addr[`GPU_ADDR_W-1:2], 2'b00};
                        m_axil_arvalid <= 1'b1;
                        state <= FETCH_ADDR;
                    end
                end
            end
            FETCH_ADDR: begin
                if (ar_xfer) begin
                    m_axil_arvalid <= 1'b0;
                    m_axil_rready <= 1'b1;
                    state <= FETCH_DATA;
                end
            end
            FETCH_DATA: begin
                if (r_xfer) begin
                    m_axil_rready <= 1'b0;
                    cache_word <= m_axil_rdata;
                    cache_tag <= m_axil_araddr[`GPU_ADDR_W-1:2];
                    cache_valid <= 1'b1;
                    state <= FETCH_OUT;
                end
            end
            FETCH_OUT, FETCH_HIT: begin
                if (pix_xfer)
                    state <= FETCH_IDLE;
            end
            default: state <= FETCH_IDLE;
        endcase

        if (rst) begin
            state <= FETCH_IDLE;
            m_axil_arvalid <= 1'b0;
            m_axil_rready <= 1'b0;
            cache_valid <= 1'b0;
        end
    end

endmodule

// ==== hdl/fb_writer.sv ====
`timescale 1ns/10ps

module fb_writer (
    input  logic clk,
    input  logic rst,
    pixel_if.sink solid,
    pixel_if.sink fetched,
    output gpu_pkg::coord_t fb_x,
    output gpu_pkg::coord_t fb_y,
    output gpu_pkg::colour_t fb_colour,
    output logic fb_write,
    output logic idle
);
    import gpu_pkg::*;

    logic rdy;

    assign solid.ready = rdy;
    assign fetched.ready = rdy && !solid.valid; // solid has priority

    wire solid_xfer = solid.valid && solid.ready;
    wire fetch_xfer = fetched.valid && fetched.ready;

    assign idle = !fb_write;

    always_ff @(posedge clk) begin
        rdy <= 1'b1;
        fb_write <= solid_xfer || fetch_xfer;
        if (solid_xfer) begin
            fb_x <= solid.x;
            fb_y <= solid.y;
            fb_colour <= solid.colour;
        end else if (fetch_xfer) begin
            fb_x <= fetched.x;
            fb_y <= fetched.y;
            fb_colour <= fetched.colour;
        end

        if (rst) begin
            rdy <= 1'b0;
            fb_write <= 1'b0;
        end
    end

endmodule

// ==== hdl/gpu_top.sv ====
`timescale 1ns/10ps

module gpu_top (
    input  logic clk,
    input  logic rst,

    input  gpu_pkg::addr_t image_start,
    input  gpu_pkg::coord_t image_x,
    input  gpu_pkg::coord_t image_y,
    input  gpu_pkg::coord_t image_width,
    input  gpu_pkg::coord_t screen_x,
    input  gpu_pkg::coord_t screen_y,
    input  gpu_pkg::coord_t excerpt_width,
    input  gpu_pkg::coord_t excerpt_height,
    input  logic flip_x,
    input  logic flip_y,
    input  gpu_pkg::colour_t draw_colour,
    input  gpu_pkg::draw_src_e colour_source,
    input  logic command_draw,
    output logic is_busy,

    // axi-lite read master
    output gpu_pkg::addr_t m_axil_araddr,
    output logic m_axil_arvalid,
    input  logic m_axil_arready,
    input  logic [31:0] m_axil_rdata,
    input  logic m_axil_rvalid,
    output logic m_axil_rready,

    output gpu_pkg::coord_t fb_x,
    output gpu_pkg::coord_t fb_y,
    output gpu_pkg::colour_t fb_colour,
    output logic fb_write
);
    import gpu_pkg::*;

    logic walker_idle;
    logic addr_idle;
    logic fetch_idle;
    logic fb_idle;

    walk_if coord_bus ();
    fetch_req_if req_bus ();
    pixel_if solid_bus ();
    pixel_if fetched_bus ();

    // busy until every stage has drained
    assign is_busy = !(walker_idle && addr_idle && fetch_idle && fb_idle);

    rect_walker walker0 (
        .clk(clk),
        .rst(rst),
        .cmd_valid(command_draw && !is_busy),
        .cmd_ready(walker_idle),
        .sheet_x(image_x),
        .sheet_y(image_y),
        .screen_x(screen_x),
        .screen_y(screen_y),
        .width(excerpt_width),
        .height(excerpt_height),
        .mirror_x(flip_x),
        .mirror_y(flip_y),
        .source(colour_source),
        .draw_colour(draw_colour),
        .coord(coord_bus.source),
        .solid(solid_bus.source)
    );

    pixel_address address0 (
        .clk(clk),
        .rst(rst),
        .image_start(image_start),
        .image_width(image_width),
        .coord(coord_bus.sink),
        .req(req_bus.source),
        .idle(addr_idle)
    );

    pixel_fetch fetch0 (
        .clk(clk),
        .rst(rst),
        .req(req_bus.sink),
        .pix(fetched_bus.source),
        .m_axil_araddr(m_axil_araddr),
        .m_axil_arvalid(m_axil_arvalid),
        .m_axil_arready(m_axil_arready),
        .m_axil_rdata(m_axil_rdata),
        .m_axil_rvalid(m_axil_rvalid),
        .m_axil_rready(m_axil_rready),
        .idle(fetch_idle)
    );

    fb_writer writer0 (
        .clk(clk),
        .rst(rst),
        .solid(solid_bus.sink),
        .fetched(fetched_bus.sink),
        .fb_x(fb_x),
        .fb_y(fb_y),
        .fb_colour(fb_colour),
        .fb_write(fb_write),
        .idle(fb_idle)
    );

endmodule

// ==== testbench/gpu_properties.sv ====
`timescale 1ns/10ps
`include "gpu_config.svh"

module gpu_properties (
    input logic clk,
    input logic rst,
    input gpu_pkg::addr_t m_axil_araddr,
    input logic m_axil_arvalid,
    input logic m_axil_arready,
    input logic m_axil_rready,
    input gpu_pkg::coord_t fb_x,
    input gpu_pkg::coord_t fb_y,
    input logic fb_write
);
    import gpu_pkg::*;

    int fail_count = 0;

    // synchronous reset clears the outputs one edge later
    reset_clears: assert property (@(posedge clk)
        rst |=> !fb_write && !m_axil_arvalid && !m_axil_rready)
        else begin
            $error("fb_write or an axi valid still high during reset");
            fail_count++;
        end

    ar_held: assert property (@(posedge clk) disable iff (rst)
        m_axil_arvalid && !m_axil_arready |=> m_axil_arvalid && $stable(m_axil_araddr))
        else begin
            $error("read address dropped or changed before arready");
            fail_count++;
        end

    ar_aligned: assert property (@(posedge clk) disable iff (rst)
        m_axil_arvalid |-> m_axil_araddr[1:0] == 2'b00)
        else begin
            $error("read address not word aligned");
            fail_count++;
        end

    rready_after_ar: assert property (@(posedge clk) disable iff (rst)
        $rose(m_axil_rready) |-> $past(m_axil_arvalid && m_axil_arready))
        else begin
            $error("rready raised without an address transfer");
            fail_count++;
        end

    write_in_bounds: assert property (@(posedge clk) disable iff (rst)
        fb_write |-> fb_x < coord_t'(`GPU_FB_WIDTH) && fb_y < coord_t'(`GPU_FB_HEIGHT))
        else begin
            $error("framebuffer write outside the screen");
            fail_count++;
        end

endmodule

// ==== testbench/gpu_tb.sv ====
`timescale 1ns/10ps
`include "gpu_config.svh"

module gpu_tb;
    import gpu_pkg::*;

    localparam int seed = 1;
    localparam int timeout_cycles = 2000;

    logic clk = 1'b0;
    logic rst = 1'b1;
    addr_t image_start = '0;
    coord_t image_x = '0;
    coord_t image_y = '0;
    coord_t image_width = '0;
    coord_t screen_x = '0;
    coord_t screen_y = '0;
    coord_t excerpt_width = '0;
    coord_t excerpt_height = '0;
    logic flip_x = 1'b0;
    logic flip_y = 1'b0;
    colour_t draw_colour = '0;
    draw_src_e colour_source = SRC_SOLID;
    logic command_draw = 1'b0;
    logic is_busy;
    addr_t m_axil_araddr;
    logic m_axil_arvalid;
    logic m_axil_arready = 1'b0;
    logic [31:0] m_axil_rdata = '0;
    logic m_axil_rvalid = 1'b0;
    logic m_axil_rready;
    coord_t fb_x;
    coord_t fb_y;
    colour_t fb_colour;
    logic fb_write;

    logic [47:0] exp_q[$]; // {x, y, colour}
    int value_errors = 0;
    int flow_errors = 0;
    int write_count = 0;
    int ar_count = 0;

    // memory model state
    logic ar_seen = 1'b0;
    logic r_seen = 1'b0;
    logic rst_seen = 1'b1;
    logic data_due = 1'b0;
    addr_t rd_addr = '0;
    int ar_delay = 0;
    int r_delay = 0;

    always #2 clk = ~clk;

    gpu_top dut0 (.*);

    bind gpu_top gpu_properties props0 (.*);

    // bus transfers as seen on the rising edge
    always @(posedge clk) begin
        rst_seen <= rst;
        ar_seen <= m_axil_arvalid && m_axil_arready;
        r_seen <= m_axil_rvalid && m_axil_rready;
        if (m_axil_arvalid && m_axil_arready) begin
            rd_addr <= m_axil_araddr;
            ar_count <= ar_count + 1;
        end
    end

    // axi-lite slave, word w holds {w[15:0] + 2, w[15:0]}
    always @(negedge clk) begin
        if (rst_seen) begin
            m_axil_arready <= 1'b0;
            m_axil_rvalid <= 1'b0;
            data_due = 1'b0;
            ar_delay = $urandom % 4;
        end else begin
            if (ar_seen) begin
                m_axil_arready <= 1'b0;
                data_due = 1'b1;
                r_delay = $urandom % 4;
                ar_delay = $urandom % 4;
            end else if (m_axil_arvalid && !m_axil_arready) begin
                if (ar_delay == 0)
                    m_axil_arready <= 1'b1;
                else
                    ar_delay--;
            end
            if (r_seen) begin
                m_axil_rvalid <= 1'b0;
            end else if (data_due) begin
                if (r_delay == 0) begin
                    m_axil_rvalid <= 1'b1;
                    m_axil_rdata <= {rd_addr[15:0] + 16'd2, rd_addr[15:0]};
                    data_due = 1'b0;
                end else begin
                    r_delay--;
                end
            end
        end
    end

    // scoreboard
    always @(posedge clk) begin
        logic [47:0] e;
        if (fb_write) begin
            write_count++;
            assert (exp_q.size() != 0) else begin
                $display("Unexpected framebuffer write at %0t to (%0d, %0d)", $time, fb_x, fb_y);
                value_errors++;
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                assert (fb_x == e[47:32]) else begin
                    $display("Mismatch at %0t: fb_x is %0d, expected %0d", $time, fb_x, e[47:32]);
                    value_errors++;
                end
                assert (fb_y == e[31:16]) else begin
                    $display("Mismatch at %0t: fb_y is %0d, expected %0d", $time, fb_y, e[31:16]);
                    value_errors++;
                end
                assert (fb_colour == e[15:0]) else begin
                    $display("Mismatch at %0t: fb_colour is %h, expected %h",
                             $time, fb_colour, e[15:0]);
                    value_errors++;
                end
            end
        end
    end

    task automatic set_cmd(input int sx, input int sy, input int w, input int h,
                           input logic mx, input logic my);
        screen_x = coord_t'(sx);
        screen_y = coord_t'(sy);
        excerpt_width = coord_t'(w);
        excerpt_height = coord_t'(h);
        flip_x = mx;
        flip_y = my;
    endtask

    // row-major walk over offsets, clipped pixels left out
    task automatic push_expected();
        int ox;
        int oy;
        int px;
        int py;
        addr_t b;
        colour_t c;
        for (oy = 0; oy < int'(excerpt_height); oy++) begin
            for (ox = 0; ox < int'(excerpt_width); ox++) begin
                px = flip_x ? int'(screen_x) + int'(excerpt_width) - 1 - ox : int'(screen_x) + ox;
                py = flip_y ? int'(screen_y) + int'(excerpt_height) - 1 - oy : int'(screen_y) + oy;
                b = image_start + addr_t'(`GPU_BYTES_PER_PIXEL *
                    (int'(image_x) + ox + int'(image_width) * (int'(image_y) + oy)));
                c = (colour_source == SRC_MEMORY) ? b[15:0] : draw_colour;
                if (px < `GPU_FB_WIDTH && py < `GPU_FB_HEIGHT)
                    exp_q.push_back({coord_t'(px), coord_t'(py), c});
            end
        end
    endtask

    task automatic start_draw();
        @(negedge clk);
        command_draw = 1'b1;
        @(negedge clk);
        command_draw = 1'b0;
        assert (is_busy) else begin
            $display("is_busy did not rise after a command at %0t", $time);
            flow_errors++;
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (is_busy && n < timeout_cycles) begin
            @(negedge clk);
            n++;
        end
        assert (!is_busy) else begin
            $display("Timeout at %0t: is_busy still high after %0d cycles", $time, n);
            flow_errors++;
        end
    endtask

    task automatic check_drained();
        assert (exp_q.size() == 0) else begin
            $display("%0d expected framebuffer writes missing at %0t", exp_q.size(), $time);
            flow_errors++;
            exp_q.delete();
        end
    endtask

    task automatic run_cmd();
        push_expected();
        start_draw();
        wait_idle();
        check_drained();
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst = 1'b1;
        repeat (4) @(negedge clk);
        rst = 1'b0;
    endtask

    initial begin
        int ar_base;
        int wr_base;
        int n;
        int total;
        void'($urandom(seed));
        repeat (4) @(negedge clk);
        rst = 1'b0;

        // plain solid rectangle
        colour_source = SRC_SOLID;
        draw_colour = 16'hf81f;
        set_cmd(10, 20, 5, 3, 1'b0, 1'b0);
        run_cmd();

        // mirrored in x, then in both
        draw_colour = 16'h07e0;
        set_cmd(100, 50, 4, 3, 1'b1, 1'b0);
        run_cmd();
        set_cmd(30, 40, 3, 4, 1'b1, 1'b1);
        run_cmd();

        // right and bottom edge clipping, then fully off-screen
        draw_colour = 16'h001f;
        set_cmd(396, 237, 8, 6, 1'b0, 1'b0);
        run_cmd();
        set_cmd(500, 10, 4, 4, 1'b0, 1'b0);
        run_cmd();

        // sprite sheet source, odd start column so words split
        colour_source = SRC_MEMORY;
        image_start = 32'h0000_1000;
        image_x = 16'd3;
        image_y = 16'd2;
        image_width = 16'd64;
        set_cmd(50, 60, 6, 4, 1'b0, 1'b0);
        ar_base = ar_count;
        run_cmd();
        assert (ar_count - ar_base < 24) else begin
            $display("cache gave no hits: %0d address transfers for 24 pixels",
                     ar_count - ar_base);
            flow_errors++;
        end

        // empty rectangles
        colour_source = SRC_SOLID;
        set_cmd(20, 20, 0, 3, 1'b0, 1'b0);
        run_cmd();
        set_cmd(20, 20, 3, 0, 1'b0, 1'b0);
        run_cmd();

        // command_draw kept high for every busy cycle, walker idle ones too
        draw_colour = 16'hffe0;
        set_cmd(200, 100, 5, 3, 1'b0, 1'b0);
        push_expected();
        start_draw();
        command_draw = 1'b1;
        n = 0;
        while (is_busy && n < timeout_cycles) begin
            @(negedge clk);
            n++;
        end
        command_draw = 1'b0;
        wait_idle();
        check_drained();

        // reset part way through a memory command
        colour_source = SRC_MEMORY;
        set_cmd(70, 80, 6, 4, 1'b1, 1'b0);
        push_expected();
        wr_base = write_count;
        start_draw();
        n = 0;
        while (write_count < wr_base + 3 && n < timeout_cycles) begin
            @(negedge clk);
            n++;
        end
        assert (write_count >= wr_base + 3) else begin
            $display("Timeout at %0t: no framebuffer writes from the memory command", $time);
            flow_errors++;
        end
        apply_reset();
        exp_q.delete();
        assert (!fb_write && !m_axil_arvalid && !m_axil_rready && !is_busy) else begin
            $display("outputs not cleared by reset at %0t", $time);
            flow_errors++;
        end
        colour_source = SRC_SOLID;
        draw_colour = 16'h1234;
        set_cmd(0, 0, 4, 2, 1'b0, 1'b0);
        run_cmd();

        repeat (4) @(negedge clk);
        total = value_errors + flow_errors + dut0.props0.fail_count;
        $display("Error counts: %0d value, %0d flow, %0d property",
                 value_errors, flow_errors, dut0.props0.fail_count);
        if (total == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+hdl
hdl/gpu_pkg.sv
hdl/gpu_ifs.sv
hdl/rect_walker.sv
hdl/pixel_address.sv
hdl/pixel_fetch.sv
hdl/fb_writer.sv
hdl/gpu_top.sv
testbench/gpu_properties.sv
testbench/gpu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with verilator, run it and scan the log
set -u
cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sim.f --top-module gpu_tb -o gpu_sim \
    && ./obj_dir/gpu_sim +verilator+error+limit+1000 2>&1 | tee sim.log \
    || echo "build or run did not complete"

# a missing log or missing pass line also counts as failure
grep -q "Done: errors found" sim.log && { echo "FAIL"; exit 1; }
grep -q "Done: no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
